// ==== common/mob_pkg.sv ====
/* Result buffer shared types */

`default_nettype none

package mob_pkg;

    // ------------------------------------------------------------------------
    // Array geometry
    // ------------------------------------------------------------------------

    // One module result: 16-bit element, chunk of 2, one core by one core
    localparam int RESULT_W      = 32;
    // Module results per input beat, module 0 in the low bits
    localparam int TOTAL_MODULES = 4;
    // Entry address width, caps a frame at 256 entries
    localparam int ADDR_W        = 8;

    // ------------------------------------------------------------------------
    // Types
    // ------------------------------------------------------------------------

    typedef logic [RESULT_W-1:0]               result_t;
    typedef logic [RESULT_W*TOTAL_MODULES-1:0] beat_t;
    typedef logic [ADDR_W-1:0]                 entry_addr_t;

    // Role of one RAM bank
    typedef enum logic [1:0] {
        BANK_EMPTY,
        BANK_FILLING,
        BANK_FULL,
        BANK_DRAINING
    } bank_state_e;

    // One result with its position in the frame
    typedef struct packed {
        result_t     data;
        entry_addr_t index;
        logic        last;
    } entry_t;

endpackage

`default_nettype wire

// ==== pingpong_buffer/bank_ctrl.sv ====
/* Ping-pong bank role controller */

`default_nettype none

module bank_ctrl
    import mob_pkg::*;
#(
    parameter int BEATS_PER_FRAME = 4
) (
    input  wire  clk,
    input  wire  rst_n,
    input  wire  wr_frame_done,
    input  wire  rd_frame_done,
    output logic wr_ready,
    output logic fill_bank,
    output logic drain_valid,
    output logic drain_bank
);

    localparam int FRAME_DEPTH = BEATS_PER_FRAME * TOTAL_MODULES;

    // Frame must fit the entry address space
    if (BEATS_PER_FRAME < 1 || FRAME_DEPTH > 2**ADDR_W) begin : g_depth_check
        $error("Frame depth out of range for ADDR_W");
    end

    bank_state_e st_q   [2];
    bank_state_e st_nxt [2];

    // ------------------------------------------------------------------------
    // Next-state logic
    // ------------------------------------------------------------------------

    always_comb begin
        logic fill_busy;
        logic drain_busy;

        // Frame completions first
        for (int b = 0; b < 2; b++) begin
            st_nxt[b] = st_q[b];
            case (st_q[b])
                BANK_FILLING:  if (wr_frame_done) st_nxt[b] = BANK_FULL;
                BANK_DRAINING: if (rd_frame_done) st_nxt[b] = BANK_EMPTY;
                default:       st_nxt[b] = st_q[b];
            endcase
        end

        // Free bank takes over filling with bank 0 first out of reset
        fill_busy = (st_nxt[0] == BANK_FILLING) || (st_nxt[1] == BANK_FILLING);
        if (!fill_busy) begin
            if (st_q[0] == BANK_EMPTY) begin
                st_nxt[0] = BANK_FILLING;
            end else if (st_q[1] == BANK_EMPTY) begin
                st_nxt[1] = BANK_FILLING;
            end
        end

        // Hand a full frame to the read side once it is idle
        // At most one bank waits in FULL so frame order is kept
        drain_busy = (st_nxt[0] == BANK_DRAINING) || (st_nxt[1] == BANK_DRAINING);
        if (!drain_busy) begin
            if (st_q[0] == BANK_FULL) begin
                st_nxt[0] = BANK_DRAINING;
            end else if (st_q[1] == BANK_FULL) begin
                st_nxt[1] = BANK_DRAINING;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            st_q[0] <= BANK_EMPTY;
            st_q[1] <= BANK_EMPTY;
        end else begin
            st_q[0] <= st_nxt[0];
            st_q[1] <= st_nxt[1];
        end
    end

    // ------------------------------------------------------------------------
    // Outputs
    // ------------------------------------------------------------------------

    assign wr_ready    = (st_q[0] == BANK_FILLING) || (st_q[1] == BANK_FILLING);
    assign fill_bank   = (st_q[1] == BANK_FILLING);
    assign drain_valid = (st_q[0] == BANK_DRAINING) || (st_q[1] == BANK_DRAINING);
    assign drain_bank  = (st_q[1] == BANK_DRAINING);

    // One filler and one drainer at most
    a_one_filler: assert property (@(posedge clk) disable iff (!rst_n)
        !(st_q[0] == BANK_FILLING && st_q[1] == BANK_FILLING))
        else $error("Both banks FILLING");

    a_one_drainer: assert property (@(posedge clk) disable iff (!rst_n)
        !(st_q[0] == BANK_DRAINING && st_q[1] == BANK_DRAINING))
        else $error("Both banks DRAINING");

endmodule

`default_nettype wire

// ==== pingpong_buffer/addr_counter.sv ====
/* Frame entry counter */

`default_nettype none

module addr_counter
    import mob_pkg::*;
#(
    parameter int BEATS_PER_FRAME = 4
) (
    input  wire         clk,
    input  wire         rst_n,
    input  wire         step,
    output entry_addr_t addr,
    output logic        frame_done
);

    localparam int          FRAME_DEPTH = BEATS_PER_FRAME * TOTAL_MODULES;
    localparam entry_addr_t LAST_ADDR   = entry_addr_t'(FRAME_DEPTH - 1);

    // Pulses with the step that writes or reads the final entry
    assign frame_done = step && (addr == LAST_ADDR);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            addr <= '0;
        end else if (step) begin
            // Wrap at frame depth, not at the address width
            if (frame_done) begin
                addr <= '0;
            end else begin
                addr <= addr + 1'b1;
            end
        end
    end

    a_addr_range: assert property (@(posedge clk) disable iff (!rst_n)
        int'(addr) < FRAME_DEPTH)
        else $error("Entry address beyond frame depth");

endmodule

`default_nettype wire

// ==== pingpong_buffer/bram_bank.sv ====
/* Inferred dual-port RAM bank */

`default_nettype none

module bram_bank
    import mob_pkg::*;
(
    input  wire         clk,
    input  wire         we,
    input  entry_addr_t waddr,
    input  result_t     wdata,
    input  entry_addr_t raddr,
    output result_t     rdata
);

    localparam int DEPTH = 2**ADDR_W;

    // One result per entry, full address space
    result_t mem [DEPTH];

    // ------------------------------------------------------------------------
    // Write port
    // ------------------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // ------------------------------------------------------------------------
    // Read port
    // ------------------------------------------------------------------------

    // Registered read, data valid one cycle after raddr
    always_ff @(posedge clk) begin
        rdata <= mem[raddr];
    end

endmodule

`default_nettype wire

// ==== hdl/result_serializer.sv ====
/* Beat to module result serializer */

`default_nettype none

module result_serializer
    import mob_pkg::*;
(
    input  wire     clk,
    input  wire     rst_n,
    input  wire     in_valid,
    input  beat_t   in_beat,
    output logic    in_ready,
    output logic    wr_valid,
    output result_t wr_data,
    input  wire     wr_ready
);

    localparam int SLICE_W = $clog2(TOTAL_MODULES);

    typedef logic [SLICE_W-1:0] slice_t;

    localparam slice_t LAST_SLICE = slice_t'(TOTAL_MODULES - 1);

    beat_t  beat_q;
    slice_t slice_q;
    logic   busy_q;
    logic   last_slice;
    logic   accept;
    logic   xfer;

    assign last_slice = (slice_q == LAST_SLICE);
    assign xfer       = wr_valid && wr_ready;
    assign accept     = in_valid && in_ready;

    // Take a beat when idle, or as the last slice leaves
    // Held off while no bank is filling
    assign in_ready = wr_ready && (!busy_q || last_slice);

    assign wr_valid = busy_q;
    // Module results go out low to high
    assign wr_data  = beat_q[slice_q*RESULT_W +: RESULT_W];

    // ------------------------------------------------------------------------
    // Slice control
    // ------------------------------------------------------------------------

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy_q  <= 1'b0;
            slice_q <= '0;
        end else if (accept) begin
            busy_q  <= 1'b1;
            slice_q <= '0;
        end else if (xfer) begin
            if (last_slice) begin
                busy_q  <= 1'b0;
                slice_q <= '0;
            end else begin
                slice_q <= slice_q + 1'b1;
            end
        end
    end

    // Beat payload
    always_ff @(posedge clk) begin
        if (accept) begin
            beat_q <= in_beat;
        end
    end

    // New beat only on an empty serializer or on the final slice transfer
    a_no_overrun: assert property (@(posedge clk) disable iff (!rst_n)
        accept |-> (!busy_q || (last_slice && xfer)))
        else $error("Beat accepted with slices pending");

endmodule

`default_nettype wire

// ==== hdl/read_pipe.sv ====
/* Bank read pipe with output skid buffer */

`default_nettype none

module read_pipe
    import mob_pkg::*;
#(
    parameter int BEATS_PER_FRAME = 4
) (
    input  wire         clk,
    input  wire         rst_n,
    input  wire         drain_valid,
    input  wire         drain_bank,
    input  entry_addr_t rd_addr,
    output logic        rd_step,
    output logic        rd_bank,
    input  result_t     bank_rdata,
    output logic        out_valid,
    output entry_t      out_entry,
    input  wire         out_ready
);

    localparam int          FRAME_DEPTH = BEATS_PER_FRAME * TOTAL_MODULES;
    localparam entry_addr_t LAST_ADDR   = entry_addr_t'(FRAME_DEPTH - 1);

    // In-flight read
    logic        inflight_q;
    logic        inf_bank_q;
    entry_addr_t inf_index_q;
    logic        inf_last_q;

    // Skid buffer with slot 0 as head
    entry_t      skid_q [2];
    logic [1:0]  cnt_q;
    entry_t      ret_entry;
    logic        push;
    logic        pop;
    logic [2:0]  occupancy;

    assign push = inflight_q;
    assign pop  = out_valid && out_ready;

    // Entries held after this cycle without a new read
    assign occupancy = 3'(cnt_q) + 3'(inflight_q) - 3'(pop);

    // Room for the returning result plus one more
    assign rd_step = drain_valid && (occupancy <= 3'd1);
    assign rd_bank = inflight_q ? inf_bank_q : drain_bank;

    assign ret_entry = '{data: bank_rdata, index: inf_index_q, last: inf_last_q};

    assign out_valid = (cnt_q != 2'd0);
    assign out_entry = skid_q[0];

    // ------------------------------------------------------------------------
    // Read issue
    // ------------------------------------------------------------------------

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            inflight_q <= 1'b0;
            inf_bank_q <= 1'b0;
        end else begin
            inflight_q <= rd_step;
            if (rd_step) begin
                inf_bank_q <= drain_bank;
            end
        end
    end

    // Position of the in-flight entry
    always_ff @(posedge clk) begin
        if (rd_step) begin
            inf_index_q <= rd_addr;
            inf_last_q  <= (rd_addr == LAST_ADDR);
        end
    end

    // ------------------------------------------------------------------------
    // Skid buffer
    // ------------------------------------------------------------------------

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt_q <= 2'd0;
        end else begin
            cnt_q <= cnt_q + 2'(push) - 2'(pop);
        end
    end

    // Head moves only on a pop or on a push into an empty buffer
    always_ff @(posedge clk) begin
        case ({push, pop})
            2'b10: skid_q[cnt_q[0]] <= ret_entry;
            2'b01: skid_q[0] <= skid_q[1];
            2'b11: begin
                if (cnt_q == 2'd1) begin
                    skid_q[0] <= ret_entry;
                end else begin
                    skid_q[0] <= skid_q[1];
                    skid_q[1] <= ret_entry;
                end
            end
            default: ;
        endcase
    end

    a_skid_room: assert property (@(posedge clk) disable iff (!rst_n)
        push |-> (cnt_q < 2'd2 || pop))
        else $error("Skid buffer overflow");

endmodule

`default_nettype wire

// ==== hdl/matmul_out_buffer.sv ====
/* Matmul result ping-pong buffer */

`default_nettype none

module matmul_out_buffer
    import mob_pkg::*;
#(
    parameter int BEATS_PER_FRAME = 4
) (
    input  wire    clk,
    input  wire    rst_n,
    input  wire    in_valid,
    input  beat_t  in_beat,
    output logic   in_ready,
    output logic   out_valid,
    output entry_t out_entry,
    input  wire    out_ready
);

    // Write side
    logic        wr_valid;
    logic        wr_ready;
    result_t     wr_data;
    logic        wr_fire;
    entry_addr_t wr_addr;
    logic        wr_frame_done;
    logic        fill_bank;

    // Read side
    logic        drain_valid;
    logic        drain_bank;
    logic        rd_step;
    logic        rd_bank;
    entry_addr_t rd_addr;
    logic        rd_frame_done;
    result_t     rdata0;
    result_t     rdata1;
    result_t     bank_rdata;

    // ------------------------------------------------------------------------
    // Write path
    // ------------------------------------------------------------------------

    result_serializer u_ser (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_valid (in_valid),
        .in_beat  (in_beat),
        .in_ready (in_ready),
        .wr_valid (wr_valid),
        .wr_data  (wr_data),
        .wr_ready (wr_ready)
    );

    assign wr_fire = wr_valid && wr_ready;

    addr_counter #(.BEATS_PER_FRAME(BEATS_PER_FRAME)) wr_cnt (
        .clk        (clk),
        .rst_n      (rst_n),
        .step       (wr_fire),
        .addr       (wr_addr),
        .frame_done (wr_frame_done)
    );

    bank_ctrl #(.BEATS_PER_FRAME(BEATS_PER_FRAME)) u_ctrl (
        .clk           (clk),
        .rst_n         (rst_n),
        .wr_frame_done (wr_frame_done),
        .rd_frame_done (rd_frame_done),
        .wr_ready      (wr_ready),
        .fill_bank     (fill_bank),
        .drain_valid   (drain_valid),
        .drain_bank    (drain_bank)
    );

    // ------------------------------------------------------------------------
    // Banks
    // ------------------------------------------------------------------------

    // Write enable to the filling bank only
    bram_bank bank0 (
        .clk   (clk),
        .we    (wr_fire && !fill_bank),
        .waddr (wr_addr),
        .wdata (wr_data),
        .raddr (rd_addr),
        .rdata (rdata0)
    );

    bram_bank bank1 (
        .clk   (clk),
        .we    (wr_fire && fill_bank),
        .waddr (wr_addr),
        .wdata (wr_data),
        .raddr (rd_addr),
        .rdata (rdata1)
    );

    // Return data from the bank of the in-flight read
    assign bank_rdata = rd_bank ? rdata1 : rdata0;

    // ------------------------------------------------------------------------
    // Read path
    // ------------------------------------------------------------------------

    addr_counter #(.BEATS_PER_FRAME(BEATS_PER_FRAME)) rd_cnt (
        .clk        (clk),
        .rst_n      (rst_n),
        .step       (rd_step),
        .addr       (rd_addr),
        .frame_done (rd_frame_done)
    );

    read_pipe #(.BEATS_PER_FRAME(BEATS_PER_FRAME)) u_rd (
        .clk         (clk),
        .rst_n       (rst_n),
        .drain_valid (drain_valid),
        .drain_bank  (drain_bank),
        .rd_addr     (rd_addr),
        .rd_step     (rd_step),
        .rd_bank     (rd_bank),
        .bank_rdata  (bank_rdata),
        .out_valid   (out_valid),
        .out_entry   (out_entry),
        .out_ready   (out_ready)
    );

endmodule

`default_nettype wire

// ==== dv/tb_matmul_out_buffer.sv ====
/* Result buffer testbench */

`default_nettype none

module tb_matmul_out_buffer
    import mob_pkg::*;
;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int BEATS_PER_FRAME = 4;
    localparam int FRAME_DEPTH     = BEATS_PER_FRAME * TOTAL_MODULES;
    localparam int MAX_HELD        = 2 * BEATS_PER_FRAME + 1;
    localparam int RESET_CYCLES    = 8;
    localparam int NUM_TESTS       = 5;
    localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

    typedef enum int {GAP_NONE, GAP_RAND} gap_e;
    typedef enum int {STALL_NONE, STALL_RAND, STALL_HOLD} stall_e;

    // One row per test
    typedef struct {
        int     frames;
        gap_e   gap;
        stall_e stall;
        int     hold;
    } test_row_t;

    logic   clk = 1'b0;
    logic   rst_n;
    logic   in_valid;
    beat_t  in_beat;
    logic   in_ready;
    logic   out_valid;
    entry_t out_entry;
    logic   out_ready;

    test_row_t   tests [NUM_TESTS];
    entry_t      exp_q [$];
    logic [31:0] lfsr_q = 32'd43;
    int          exp_idx = 0;
    int          accepted = 0;
    int          received = 0;
    int          errors = 0;
    int          checks = 0;
    int          cycles = 0;
    int          cycle_limit = 1_000_000;
    logic        stalled_q = 1'b0;
    entry_t      stalled_entry;

    matmul_out_buffer #(.BEATS_PER_FRAME(BEATS_PER_FRAME)) DUT (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_beat   (in_beat),
        .in_ready  (in_ready),
        .out_valid (out_valid),
        .out_entry (out_entry),
        .out_ready (out_ready)
    );

    always #4 clk = ~clk;

    // ------------------------------------------------------------------------
    // Random source
    // ------------------------------------------------------------------------

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic [31:0] n;
        n = s >> 1;
        if (s[0]) n = n ^ LFSR_TAPS;
        return n;
    endfunction

    // One LFSR step per bit
    function automatic beat_t take_bits(input int n);
        beat_t v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v[i] = lfsr_q[0];
            lfsr_q = lfsr_next(lfsr_q);
        end
        return v;
    endfunction

    // ------------------------------------------------------------------------
    // Monitor: reference model, output compare, stall stability, timeout
    // ------------------------------------------------------------------------

    always @(posedge clk) begin
        entry_t e;
        cycles++;
        if (cycles >= cycle_limit) begin
            $display("Timeout after %0d cycles", cycles);
            $display("Finished with errors");
            $finish;
        end else if (rst_n) begin
            // Accepted beat becomes four entries, module 0 first
            if (in_valid && in_ready) begin
                accepted++;
                for (int m = 0; m < TOTAL_MODULES; m++) begin
                    e.data  = in_beat[m*RESULT_W +: RESULT_W];
                    e.index = entry_addr_t'(exp_idx);
                    e.last  = (exp_idx == FRAME_DEPTH - 1);
                    exp_q.push_back(e);
                    exp_idx = (exp_idx == FRAME_DEPTH - 1) ? 0 : exp_idx + 1;
                end
            end
            // Held entry must not move under back-pressure
            if (stalled_q) begin
                if (!out_valid) begin
                    $display("out_valid dropped while out_ready was low");
                    errors++;
                end else if (out_entry != stalled_entry) begin
                    $display("Mismatch out_entry (stalled): got %h expected %h",
                             out_entry, stalled_entry);
                    errors++;
                end
            end
            stalled_q     = out_valid && !out_ready;
            stalled_entry = out_entry;
            if (out_valid && out_ready) begin
                received++;
                checks++;
                if (exp_q.size() == 0) begin
                    $display("Output entry arrived with nothing expected");
                    errors++;
                end else begin
                    e = exp_q.pop_front();
                    if (out_entry.data != e.data) begin
                        $display("Mismatch out_entry.data: got %h expected %h",
                                 out_entry.data, e.data);
                        errors++;
                    end
                    if (out_entry.index != e.index) begin
                        $display("Mismatch out_entry.index: got %h expected %h",
                                 out_entry.index, e.index);
                        errors++;
                    end
                    if (out_entry.last != e.last) begin
                        $display("Mismatch out_entry.last: got %h expected %h",
                                 out_entry.last, e.last);
                        errors++;
                    end
                end
            end
        end
    end

    // ------------------------------------------------------------------------
    // Drivers
    // ------------------------------------------------------------------------

    task automatic send_beats(input int beats, input gap_e gap);
        beat_t gap_bits;
        for (int b = 0; b < beats; b++) begin
            if (gap == GAP_RAND) begin
                gap_bits = take_bits(2);
                in_valid <= 1'b0;
                repeat (int'(gap_bits[1:0])) @(posedge clk);
            end
            in_valid <= 1'b1;
            in_beat  <= take_bits(RESULT_W * TOTAL_MODULES);
            @(posedge clk);
            while (!in_ready) @(posedge clk);
        end
        in_valid <= 1'b0;
    endtask

    task automatic drive_ready(input stall_e stall, input int hold, input int target);
        beat_t bits;
        if (stall == STALL_HOLD) begin
            out_ready <= 1'b0;
            repeat (hold) @(posedge clk);
            // Both banks full, serializer holds at most one beat
            if (in_ready) begin
                $display("in_ready still high with both banks full");
                errors++;
            end
            if (accepted > MAX_HELD || accepted < 2 * BEATS_PER_FRAME) begin
                $display("Wrong beat count during output hold: %0d", accepted);
                errors++;
            end
        end
        out_ready <= 1'b1;
        while (received < target) begin
            if (stall == STALL_RAND) begin
                bits = take_bits(1);
                out_ready <= bits[0];
            end
            @(posedge clk);
        end
        out_ready <= 1'b1;
    endtask

    // ------------------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------------------

    task automatic check_reset();
        int waited;
        waited = 0;
        @(posedge clk);
        if (out_valid) begin
            $display("out_valid high right after reset");
            errors++;
        end
        while (!in_ready && waited < 2) begin
            @(posedge clk);
            waited++;
        end
        if (!in_ready) begin
            $display("in_ready not high within two cycles of reset release");
            errors++;
        end
        $display("Test reset: done, errors so far %0d", errors);
    endtask

    task automatic run_test(input int t);
        int err_start;
        int target;
        err_start = errors;
        accepted  = 0;
        received  = 0;
        target    = tests[t].frames * FRAME_DEPTH;
        fork
            send_beats(tests[t].frames * BEATS_PER_FRAME, tests[t].gap);
            drive_ready(tests[t].stall, tests[t].hold, target);
        join
        @(posedge clk);
        if (out_valid || exp_q.size() != 0) begin
            $display("Output stream left %0d entries unmatched", exp_q.size());
            errors++;
        end
        $display("Test %0d: %0d frames, %0d entries, %0d errors",
                 t, tests[t].frames, received, errors - err_start);
    endtask

    initial begin
        int frames_total;
        rst_n     = 1'b0;
        in_valid  = 1'b0;
        in_beat   = '0;
        out_ready = 1'b0;

        // Frames, input gaps, output stall, hold cycles
        tests[0] = '{1, GAP_NONE, STALL_NONE, 0};
        tests[1] = '{4, GAP_RAND, STALL_NONE, 0};
        tests[2] = '{3, GAP_NONE, STALL_RAND, 0};
        tests[3] = '{4, GAP_RAND, STALL_RAND, 0};
        tests[4] = '{4, GAP_NONE, STALL_HOLD, 100};

        frames_total = 0;
        for (int t = 0; t < NUM_TESTS; t++) frames_total += tests[t].frames;
        cycle_limit = frames_total * FRAME_DEPTH * 4 + 200;

        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        check_reset();
        for (int t = 0; t < NUM_TESTS; t++) run_test(t);

        $display("Tests: %0d, entries checked: %0d, errors: %0d", NUM_TESTS, checks, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== matmul_out_buffer.f ====
common/mob_pkg.sv
pingpong_buffer/bank_ctrl.sv
pingpong_buffer/addr_counter.sv
pingpong_buffer/bram_bank.sv
hdl/result_serializer.sv
hdl/read_pipe.sv
hdl/matmul_out_buffer.sv
dv/tb_matmul_out_buffer.sv

// ==== Makefile ====
# Verilator build and run for the matmul result buffer

VERILATOR ?= verilator
TOP       := tb_matmul_out_buffer
FILELIST  := matmul_out_buffer.f
VFLAGS    := --binary --timing --assert -j 0
BUILD_DIR := obj_dir
LOG       := sim.log
PASS_MSG  := Finished with no errors

SOURCES   := $(shell cat $(FILELIST))
SIM_BIN   := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

# Pass only when the log holds the pass line
run: compile
	./$(SIM_BIN) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || (echo "Simulation failed" && exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
